// File: run.sh
#!/usr/bin/env bash
# build with Verilator from the file list, run, and pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -Wno-fatal -f sim.f --top-module stripe_tb -o stripe_sim \
  && ./obj_dir/stripe_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
  && echo "stripe run passed" \
  || { echo "stripe run failed"; exit 1; }

// File: sim.f
+incdir+.
stripe_pkg.sv
stripe_wr.sv
stripe_bank.sv
stripe_rd_port.sv
stripe_top.sv
stripe_props.sv
stripe_chk.sv
stripe_tb.sv

// File: stripe_bank.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_bank import stripe_pkg::*; #(
  parameter int WORD_W = `STRIPE_ADDR_W - $clog2(`STRIPE_DATA_W / 8) - $clog2(`STRIPE_NUM_S)
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      aw_valid,
  input  aw_req_t                   aw,
  output logic                      aw_ready,
  input  logic                      w_valid,
  input  w_beat_t                   w,
  output logic                      w_ready,
  output logic                      b_valid,
  output b_rsp_t                    b,
  input  logic                      b_ready,
  input  logic [WORD_W-1:0]         rd_word,
  output logic [`STRIPE_DATA_W-1:0] rd_data
);

  localparam int DATA_W = `STRIPE_DATA_W;
  localparam int STRB_W = DATA_W / 8;
  localparam int O_W    = $clog2(STRB_W);
  localparam int MEM_AW = $clog2(`STRIPE_BANK_WORDS);

  // depth held at the width of the walking word index
  localparam logic [WORD_W:0] DEPTH = (WORD_W + 1)'(`STRIPE_BANK_WORDS);

  bank_state_e         state;
  logic [`STRIPE_ID_W-1:0] id_q;
  logic [WORD_W:0]     word_q;
  logic                err_q;
  logic                in_range;
  logic [DATA_W-1:0]   mem [`STRIPE_BANK_WORDS];

  // the word index has one spare bit so a walk off the end never wraps
  // back onto a valid word
  assign in_range = word_q < DEPTH;

  assign aw_ready = (state == BANK_IDLE);
  assign w_ready  = (state == BANK_DATA);
  assign b_valid  = (state == BANK_RESP);
  assign b.id     = id_q;
  assign b.resp   = err_q ? SLVERR : OKAY;

  // ----------------------------------------------------------
  // write FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= BANK_IDLE;
    end else begin
      case (state)
        BANK_IDLE: begin
          if (aw_valid) begin
            state <= BANK_DATA;
          end
        end
        BANK_DATA: begin
          if (w_valid && w.last) begin
            state <= BANK_RESP;
          end
        end
        BANK_RESP: begin
          if (b_ready) begin
            state <= BANK_IDLE;
          end
        end
        default: begin
          state <= BANK_IDLE;
        end
      endcase
    end
  end

  // the burst context is loaded on every AW
  // err_q sticks once any beat of the burst lands past the depth
  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      id_q   <= aw.id;
      word_q <= {1'b0, aw.addr[O_W+WORD_W-1:O_W]};
      err_q  <= ({1'b0, aw.addr[O_W+WORD_W-1:O_W]} >= DEPTH);
    end else if (w_valid && w_ready) begin
      word_q <= word_q + 1'b1;
      if (!in_range) begin
        err_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------

  // bytes are written under strobe in the cycle the beat arrives
  always_ff @(posedge clk) begin
    if (w_valid && w_ready && in_range) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w.strb[i]) begin
          mem[word_q[MEM_AW-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
        end
      end
    end
  end

  // words past the depth read as zero
  assign rd_data = ({1'b0, rd_word} < DEPTH) ? mem[rd_word[MEM_AW-1:0]] : '0;

endmodule

// File: stripe_cfg.svh
`ifndef STRIPE_CFG_SVH
`define STRIPE_CFG_SVH

// number of banks in the stripe, which must be a power of two
`define STRIPE_NUM_S 4

// byte address width of the caller port
`define STRIPE_ADDR_W 12

// data width of every W channel
// the strobe carries one bit per byte of this width
`define STRIPE_DATA_W 32

// transaction id width shared by AW and B
`define STRIPE_ID_W 4

// words of storage in each bank
// any bank word index at or past this depth is answered with SLVERR
`define STRIPE_BANK_WORDS 128

`endif

// File: stripe_chk.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_chk import stripe_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      aw_valid,
  input  aw_req_t                   aw,
  input  logic                      aw_ready,
  input  logic                      w_valid,
  input  w_beat_t                   w,
  input  logic                      w_ready,
  input  logic                      b_valid,
  input  b_rsp_t                    b,
  input  logic                      b_ready,
  input  logic                      rd_en,
  input  logic [`STRIPE_ADDR_W-3:0] rd_addr,
  input  logic                      rd_valid,
  input  logic [`STRIPE_DATA_W-1:0] rd_data,
  input  logic                      test_end,
  input  logic                      run_done,
  output int                        errors
);

  localparam int NUM_S  = `STRIPE_NUM_S;
  localparam int DEPTH  = `STRIPE_BANK_WORDS;
  localparam int DATA_W = `STRIPE_DATA_W;
  localparam int ROW_SH = $clog2(NUM_S) + $clog2(DATA_W / 8);

  // reference memory kept per bank and row, the way the striping lays it out
  logic [DATA_W-1:0]       model [NUM_S][DEPTH];
  int                      checks = 0;
  int                      tests = 0;
  int                      mark_checks = 0;
  int                      mark_errors = 0;
  int                      bursts = 0;
  int                      responses = 0;
  logic                    in_reset = 1'b1;
  logic                    burst_open = 1'b0;
  logic [`STRIPE_ID_W-1:0] exp_id;
  logic                    exp_err;
  int                      start_row;
  int                      beats;
  int                      beat;
  logic                    rd_pend = 1'b0;
  logic [DATA_W-1:0]       rd_exp;
  logic                    b_held = 1'b0;
  b_rsp_t                  b_last;

  initial errors = 0;

  task automatic compare_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_rule(input logic ok, input string what);
    checks++;
    if (!ok) begin
      errors++;
      $display("Error: %s at %0t", what, $time);
    end
  endtask

  // word w lives in bank w mod NUM_S, row w / NUM_S, and rows past the
  // depth read back as zero
  function automatic logic [DATA_W-1:0] expected_word(input logic [`STRIPE_ADDR_W-3:0] wa);
    int row;
    row = int'(wa) / NUM_S;
    if (row >= DEPTH) begin
      return '0;
    end
    return model[int'(wa) % NUM_S][row];
  endfunction

  // beat k of a burst goes to bank k mod NUM_S on row start + k / NUM_S
  task automatic write_beat(input w_beat_t bt);
    int row;
    row = start_row + beat / NUM_S;
    if (row >= DEPTH) begin
      exp_err = 1'b1;
    end else begin
      for (int i = 0; i < DATA_W / 8; i++) begin
        if (bt.strb[i]) begin
          model[beat % NUM_S][row][i*8 +: 8] = bt.data[i*8 +: 8];
        end
      end
    end
    beat++;
  endtask

  // ----------------------------------------------------------
  // port monitor, sampling the values settled before each edge
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      in_reset   = 1'b1;
      burst_open = 1'b0;
      rd_pend    = 1'b0;
      b_held     = 1'b0;
    end else begin
      if (in_reset) begin
        compare_value("aw_ready", DATA_W'(1), DATA_W'(aw_ready));
        compare_value("b_valid", DATA_W'(0), DATA_W'(b_valid));
        compare_value("rd_valid", DATA_W'(0), DATA_W'(rd_valid));
        in_reset = 1'b0;
      end

      // a stalled response must stay up with the same payload
      if (b_held) begin
        check_rule(b_valid, "b_valid dropped before its response was taken");
        compare_value("b", DATA_W'(b_last), DATA_W'(b));
      end
      b_held = b_valid && !b_ready;
      b_last = b;

      // a response may only be offered while its burst is still open
      if (b_valid) begin
        check_rule(burst_open, "a response was offered with no burst waiting for it");
      end

      if (aw_valid && aw_ready) begin
        check_rule(!burst_open, "a new burst was accepted before the previous response");
        burst_open = 1'b1;
        exp_id     = aw.id;
        exp_err    = 1'b0;
        start_row  = int'(aw.addr >> ROW_SH);
        beats      = int'(aw.len) + 1;
        beat       = 0;
        bursts++;
      end

      if (w_valid && w_ready) begin
        check_rule(burst_open && beat < beats, "a W beat was taken outside of a burst");
        if (burst_open) begin
          write_beat(w);
        end
      end

      if (b_valid && b_ready) begin
        if (burst_open) begin
          check_rule(beat == beats, "the response came before all W beats were taken");
          compare_value("b.id", DATA_W'(exp_id), DATA_W'(b.id));
          compare_value("b.resp", DATA_W'(exp_err ? SLVERR : OKAY), DATA_W'(b.resp));
          responses++;
        end
        burst_open = 1'b0;
      end

      // read data is due exactly one cycle after its request
      if (rd_valid || rd_pend) begin
        check_rule(rd_valid === rd_pend, "rd_valid did not follow rd_en by one cycle");
      end
      if (rd_pend) begin
        compare_value("rd_data", rd_exp, rd_data);
      end
      rd_pend = rd_en;
      if (rd_en) begin
        rd_exp = expected_word(rd_addr);
      end

      if (test_end) begin
        $display("test %0d %s: %0d checks, %0d errors", tests,
                 (errors == mark_errors) ? "ok" : "with errors",
                 checks - mark_checks, errors - mark_errors);
        tests++;
        mark_checks = checks;
        mark_errors = errors;
      end

      if (run_done) begin
        check_rule(!burst_open && responses == bursts, "a burst never got its response");
        $display("totals: %0d tests, %0d bursts, %0d checks, %0d errors",
                 tests, bursts, checks, errors);
      end
    end
  end

endmodule

// File: stripe_pkg.sv
`include "stripe_cfg.svh"

package stripe_pkg;

  // write response codes, using the AXI encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // burst types as AXI encodes them
  // the banks and the striping only handle INCR
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // per-bank write FSM
  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_DATA,
    BANK_RESP
  } bank_state_e;

  // write address request
  // at the banks the low bits of addr hold the bank byte address
  typedef struct packed {
    logic [`STRIPE_ADDR_W-1:0] addr;
    logic [`STRIPE_ID_W-1:0]   id;
    logic [7:0]                len;
    logic [2:0]                size;
    burst_e                    burst;
  } aw_req_t;

  // one write data beat
  typedef struct packed {
    logic [`STRIPE_DATA_W-1:0]   data;
    logic [`STRIPE_DATA_W/8-1:0] strb;
    logic                        last;
  } w_beat_t;

  // write response
  typedef struct packed {
    logic [`STRIPE_ID_W-1:0] id;
    resp_e                   resp;
  } b_rsp_t;

endpackage

// File: stripe_props.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_props import stripe_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    aw_valid,
  input  aw_req_t aw,
  input  logic    aw_ready,
  input  logic    w_valid,
  input  w_beat_t w,
  input  logic    w_ready,
  input  logic    b_valid,
  input  b_rsp_t  b,
  input  logic    b_ready
);

  localparam int S_W = $clog2(`STRIPE_NUM_S);
  localparam int O_W = $clog2(`STRIPE_DATA_W / 8);

  // number of failed properties, read by the testbench at the end of the run
  int viol_count = 0;

  // ----------------------------------------------------------
  // caller usage rules
  // ----------------------------------------------------------

  // a burst has to start on a full stripe so that beat 0 lands in bank 0
  aw_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> aw.addr[S_W+O_W-1:0] == '0)
    else begin
      $error("AW address is not aligned to a full stripe");
      viol_count++;
    end

  // only full width INCR beats are striped
  aw_full_incr: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> (aw.size == 3'(O_W)) && (aw.burst == INCR))
    else begin
      $error("AW is not a full width INCR burst");
      viol_count++;
    end

  // the beat count must fill whole rows
  aw_whole_rows: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid |-> aw.len[S_W-1:0] == {S_W{1'b1}})
    else begin
      $error("AW length is not a multiple of the bank count");
      viol_count++;
    end

  // ----------------------------------------------------------
  // handshake stability
  // ----------------------------------------------------------
  aw_held: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
      $error("AW request changed while it was stalled");
      viol_count++;
    end

  w_held: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
      $error("W beat changed while it was stalled");
      viol_count++;
    end

  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      $error("B response changed while it was stalled");
      viol_count++;
    end

endmodule

// File: stripe_rd_port.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_rd_port import stripe_pkg::*; #(
  parameter int WORD_W = `STRIPE_ADDR_W - $clog2(`STRIPE_DATA_W / 8) - $clog2(`STRIPE_NUM_S)
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         rd_en,
  input  logic [`STRIPE_ADDR_W-3:0]                    rd_addr,
  output logic [WORD_W-1:0]                            bank_rd_word,
  input  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_W-1:0] bank_rd_data,
  output logic                                         rd_valid,
  output logic [`STRIPE_DATA_W-1:0]                    rd_data
);

  localparam int S_W  = $clog2(`STRIPE_NUM_S);
  localparam int RA_W = `STRIPE_ADDR_W - 2;

  logic [S_W-1:0] sel;

  // consecutive words sit in consecutive banks
  // the low word bits pick the bank and the rest is the row inside it
  assign sel          = rd_addr[S_W-1:0];
  assign bank_rd_word = rd_addr[RA_W-1:S_W];

  // one cycle read latency with no back-pressure
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // the data register only loads on a request and holds otherwise
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= bank_rd_data[sel];
    end
  end

endmodule

// File: stripe_tb.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_tb import stripe_pkg::*; ();

  localparam int NUM_S       = `STRIPE_NUM_S;
  localparam int ID_W        = `STRIPE_ID_W;
  localparam int STRB_W      = `STRIPE_DATA_W / 8;
  localparam int RA_W        = `STRIPE_ADDR_W - 2;
  localparam int IN_BYTES    = NUM_S * `STRIPE_BANK_WORDS * STRB_W;
  localparam int ROW_BYTES   = NUM_S * STRB_W;
  localparam int INIT_BURSTS = IN_BYTES / (4 * ROW_BYTES);
  localparam int NUM_TESTS   = 40;
  localparam int LIMIT       = 200 * (INIT_BURSTS + NUM_TESTS) + 2000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              aw_valid;
  aw_req_t           aw;
  logic              aw_ready;
  logic              w_valid;
  w_beat_t           w;
  logic              w_ready;
  logic              b_valid;
  b_rsp_t            b;
  logic              b_ready;
  logic              rd_en;
  logic [RA_W-1:0]   rd_addr;
  logic              rd_valid;
  logic [`STRIPE_DATA_W-1:0] rd_data;
  logic              test_end;
  logic              run_done;
  int                errors;
  int                cycles = 0;
  integer            seed = 32'h78b1;

  always #5 clk = ~clk;

  stripe_top u_stripe_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  stripe_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .test_end (test_end),
    .run_done (run_done),
    .errors   (errors)
  );

  bind stripe_wr stripe_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready)
  );

  // every burst is bounded, so a stuck handshake shows up here
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // stimulus tasks, all driving 1 ns after the rising edge
  // ----------------------------------------------------------

  // raise an AW request for rows * NUM_S beats and leave it up until taken
  task automatic offer_aw(input logic [`STRIPE_ADDR_W-1:0] addr, input int rows);
    aw_valid = 1'b1;
    aw.addr  = addr;
    aw.id    = ID_W'($random(seed));
    aw.len   = 8'(rows * NUM_S - 1);
    aw.size  = 3'($clog2(STRB_W));
    aw.burst = INCR;
  endtask

  task automatic await_aw();
    do begin
      @(posedge clk);
    end while (!aw_ready);
    #1;
    aw_valid = 1'b0;
  endtask

  task automatic send_beats(input int rows, input logic full_strb);
    int beats;
    beats = rows * NUM_S;
    for (int k = 0; k < beats; k++) begin
      w_valid = 1'b1;
      w.data  = $random(seed);
      w.strb  = (full_strb || 1'($random(seed))) ? '1 : STRB_W'($random(seed));
      w.last  = (k == beats - 1);
      do begin
        @(posedge clk);
      end while (!w_ready);
      #1;
    end
    w_valid = 1'b0;
  endtask

  // the response is taken under random b_ready stalls
  task automatic await_b();
    b_ready = 1'($random(seed));
    @(posedge clk);
    while (!(b_valid && b_ready)) begin
      #1;
      b_ready = 1'($random(seed));
      @(posedge clk);
    end
    #1;
    b_ready = 1'b0;
  endtask

  task automatic run_burst(input logic [`STRIPE_ADDR_W-1:0] addr, input int rows,
                           input logic full_strb);
    offer_aw(addr, rows);
    await_aw();
    send_beats(rows, full_strb);
    await_b();
  endtask

  // random start and length, about a quarter of them allowed to run past the depth
  task automatic pick_burst(output logic [`STRIPE_ADDR_W-1:0] addr, output int rows);
    int top_rows;
    rows = 1 + int'({$random(seed)} % 4);
    top_rows = (({$random(seed)} % 4) == 0) ? 2 * IN_BYTES / ROW_BYTES
                                            : IN_BYTES / ROW_BYTES;
    addr = `STRIPE_ADDR_W'(int'({$random(seed)} % (top_rows - rows + 1)) * ROW_BYTES);
  endtask

  // back-to-back word reads, then one cycle for the last word to return
  task automatic read_words(input logic [RA_W-1:0] first, input int count);
    for (int k = 0; k < count; k++) begin
      rd_en   = 1'b1;
      rd_addr = first + RA_W'(k);
      @(posedge clk);
      #1;
    end
    rd_en = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic close_test();
    test_end = 1'b1;
    @(posedge clk);
    #1;
    test_end = 1'b0;
  endtask

  initial begin
    int rows;
    int next_rows;
    logic [`STRIPE_ADDR_W-1:0] addr;
    logic [`STRIPE_ADDR_W-1:0] next_addr;
    rst_n    = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    test_end = 1'b0;
    run_done = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // test 0 covers the values straight out of reset
    close_test();

    // fill every in-range word with full strobes so later merges are known
    for (int a = 0; a < IN_BYTES; a += 4 * ROW_BYTES) begin
      run_burst(`STRIPE_ADDR_W'(a), 4, 1'b1);
    end
    read_words('0, IN_BYTES / STRB_W);
    close_test();

    // each random burst after the first is offered while the one before
    // still waits for its response, so aw_ready has to hold it off
    pick_burst(next_addr, next_rows);
    offer_aw(next_addr, next_rows);
    await_aw();
    for (int t = 0; t < NUM_TESTS; t++) begin
      addr = next_addr;
      rows = next_rows;
      send_beats(rows, 1'b0);
      if (t < NUM_TESTS - 1) begin
        pick_burst(next_addr, next_rows);
        offer_aw(next_addr, next_rows);
      end
      await_b();
      if (t < NUM_TESTS - 1) begin
        await_aw();
      end
      // the next burst sends no beats yet, so its words stay still here
      read_words(RA_W'(addr >> 2), rows * NUM_S);
      close_test();
    end

    run_done = 1'b1;
    @(posedge clk);
    #1;
    run_done = 1'b0;
    if (errors == 0 && u_stripe_top.u_wr.u_props.viol_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: stripe_top.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_top import stripe_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  // AXI write port
  input  logic                      aw_valid,
  input  aw_req_t                   aw,
  output logic                      aw_ready,
  input  logic                      w_valid,
  input  w_beat_t                   w,
  output logic                      w_ready,
  output logic                      b_valid,
  output b_rsp_t                    b,
  input  logic                      b_ready,

  // word read port
  input  logic                      rd_en,
  input  logic [`STRIPE_ADDR_W-3:0] rd_addr,
  output logic                      rd_valid,
  output logic [`STRIPE_DATA_W-1:0] rd_data
);

  localparam int NUM_S  = `STRIPE_NUM_S;
  localparam int WORD_W = `STRIPE_ADDR_W - $clog2(`STRIPE_DATA_W / 8) - $clog2(NUM_S);

  logic    [NUM_S-1:0]                     bank_aw_valid;
  aw_req_t [NUM_S-1:0]                     bank_aw;
  logic    [NUM_S-1:0]                     bank_aw_ready;
  logic    [NUM_S-1:0]                     bank_w_valid;
  w_beat_t [NUM_S-1:0]                     bank_w;
  logic    [NUM_S-1:0]                     bank_w_ready;
  logic    [NUM_S-1:0]                     bank_b_valid;
  b_rsp_t  [NUM_S-1:0]                     bank_b;
  logic    [NUM_S-1:0]                     bank_b_ready;
  logic    [WORD_W-1:0]                    bank_rd_word;
  logic    [NUM_S-1:0][`STRIPE_DATA_W-1:0] bank_rd_data;

  // striping control between the caller and the banks
  stripe_wr u_wr (
    .clk           (clk),
    .rst_n         (rst_n),
    .aw_valid      (aw_valid),
    .aw            (aw),
    .aw_ready      (aw_ready),
    .w_valid       (w_valid),
    .w             (w),
    .w_ready       (w_ready),
    .b_valid       (b_valid),
    .b             (b),
    .b_ready       (b_ready),
    .bank_aw_valid (bank_aw_valid),
    .bank_aw       (bank_aw),
    .bank_aw_ready (bank_aw_ready),
    .bank_w_valid  (bank_w_valid),
    .bank_w        (bank_w),
    .bank_w_ready  (bank_w_ready),
    .bank_b_valid  (bank_b_valid),
    .bank_b        (bank_b),
    .bank_b_ready  (bank_b_ready)
  );

  // every bank shares the read row and returns its own word
  for (genvar i = 0; i < NUM_S; i++) begin : gen_bank
    stripe_bank #(
      .WORD_W (WORD_W)
    ) u_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .aw_valid (bank_aw_valid[i]),
      .aw       (bank_aw[i]),
      .aw_ready (bank_aw_ready[i]),
      .w_valid  (bank_w_valid[i]),
      .w        (bank_w[i]),
      .w_ready  (bank_w_ready[i]),
      .b_valid  (bank_b_valid[i]),
      .b        (bank_b[i]),
      .b_ready  (bank_b_ready[i]),
      .rd_word  (bank_rd_word),
      .rd_data  (bank_rd_data[i])
    );
  end

  stripe_rd_port #(
    .WORD_W (WORD_W)
  ) u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .bank_rd_word (bank_rd_word),
    .bank_rd_data (bank_rd_data),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

endmodule

// File: stripe_wr.sv
`timescale 1ns/1ps
`include "stripe_cfg.svh"

module stripe_wr import stripe_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,

  // caller write port
  input  logic                         aw_valid,
  input  aw_req_t                      aw,
  output logic                         aw_ready,
  input  logic                         w_valid,
  input  w_beat_t                      w,
  output logic                         w_ready,
  output logic                         b_valid,
  output b_rsp_t                       b,
  input  logic                         b_ready,

  // one write port per bank
  output logic    [`STRIPE_NUM_S-1:0] bank_aw_valid,
  output aw_req_t [`STRIPE_NUM_S-1:0] bank_aw,
  input  logic    [`STRIPE_NUM_S-1:0] bank_aw_ready,
  output logic    [`STRIPE_NUM_S-1:0] bank_w_valid,
  output w_beat_t [`STRIPE_NUM_S-1:0] bank_w,
  input  logic    [`STRIPE_NUM_S-1:0] bank_w_ready,
  input  logic    [`STRIPE_NUM_S-1:0] bank_b_valid,
  input  b_rsp_t  [`STRIPE_NUM_S-1:0] bank_b,
  output logic    [`STRIPE_NUM_S-1:0] bank_b_ready
);

  localparam int NUM_S  = `STRIPE_NUM_S;
  localparam int ADDR_W = `STRIPE_ADDR_W;
  localparam int S_W    = $clog2(NUM_S);
  localparam int O_W    = $clog2(`STRIPE_DATA_W / 8);

  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic [ADDR_W-S_W-1:0] stripe_addr;
  aw_req_t               bank_req;
  logic [NUM_S-1:0]      aw_done;
  logic [NUM_S-1:0]      b_done;
  logic [NUM_S-1:0]      b_done_next;
  logic [S_W-1:0]        idx;
  logic [7:0]            stripes_todo;

  assign aw_hs = aw_valid && aw_ready;
  assign w_hs  = w_valid && w_ready;
  assign b_hs  = b_valid && b_ready;

  // ----------------------------------------------------------
  // AW channel
  // ----------------------------------------------------------

  // the top byte address is high bits, bank index, byte offset
  // the bank sees the same address with the index bits cut out of the middle
  assign stripe_addr = {aw.addr[ADDR_W-1:S_W+O_W], aw.addr[O_W-1:0]};

  // each bank gets one row per stripe, so its length is the top length
  // divided by the bank count
  always_comb begin
    bank_req      = aw;
    bank_req.addr = {{S_W{1'b0}}, stripe_addr};
    bank_req.len  = aw.len >> S_W;
  end

  // only one burst is in flight, so the port closes on accept and
  // reopens the cycle after the caller has taken the response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_ready <= 1'b1;
    end else if (aw_hs) begin
      aw_ready <= 1'b0;
    end else if (b_hs) begin
      aw_ready <= 1'b1;
    end
  end

  // every bank request goes out together and each drops on its own ready
  // aw_done remembers which banks hold their request for this burst
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_aw_valid <= '0;
      aw_done       <= '0;
    end else begin
      for (int i = 0; i < NUM_S; i++) begin
        if (aw_hs) begin
          bank_aw_valid[i] <= 1'b1;
        end else if (bank_aw_ready[i]) begin
          bank_aw_valid[i] <= 1'b0;
        end

        if (aw_hs || b_hs) begin
          aw_done[i] <= 1'b0;
        end else if (bank_aw_valid[i] && bank_aw_ready[i]) begin
          aw_done[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      for (int i = 0; i < NUM_S; i++) begin
        bank_aw[i] <= bank_req;
      end
    end
  end

  // ----------------------------------------------------------
  // W steering
  // ----------------------------------------------------------

  // NUM_S is a power of two so the bank index simply wraps
  // stripes_todo counts whole rows still to come after the current one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx          <= '0;
      stripes_todo <= '0;
    end else if (aw_hs) begin
      idx          <= '0;
      stripes_todo <= aw.len >> S_W;
    end else if (w_hs) begin
      idx <= idx + 1'b1;
      if (idx == {S_W{1'b1}}) begin
        stripes_todo <= stripes_todo - 8'd1;
      end
    end
  end

  // a beat is only taken once the addressed bank holds its AW
  assign w_ready = bank_w_ready[idx] && aw_done[idx];

  // the accepted beat is registered toward its bank and stays up until
  // that bank takes it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_w_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_S; i++) begin
        if (w_hs && idx == S_W'(i)) begin
          bank_w_valid[i] <= 1'b1;
        end else if (bank_w_ready[i]) begin
          bank_w_valid[i] <= 1'b0;
        end
      end
    end
  end

  // the caller's wlast is not needed since every bank ends on the final row
  always_ff @(posedge clk) begin
    if (w_hs) begin
      bank_w[idx].data <= w.data;
      bank_w[idx].strb <= w.strb;
      bank_w[idx].last <= (stripes_todo == 8'd0);
    end
  end

  // ----------------------------------------------------------
  // B merge
  // ----------------------------------------------------------

  // responses are buffered here, so the banks are never stalled
  assign bank_b_ready = '1;

  always_comb begin
    for (int i = 0; i < NUM_S; i++) begin
      b_done_next[i] = b_done[i];
      if (b_hs) begin
        b_done_next[i] = 1'b0;
      end
      if (bank_b_valid[i] && bank_b_ready[i]) begin
        b_done_next[i] = 1'b1;
      end
    end
  end

  // b_valid rises the cycle after the last bank answers and holds under
  // back-pressure because b_done only clears on the caller's transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done  <= '0;
      b_valid <= 1'b0;
    end else begin
      b_done  <= b_done_next;
      b_valid <= &b_done_next;
    end
  end

  // all banks see the same rows of the same burst and so agree on id and
  // resp, and bank 0 speaks for them
  always_ff @(posedge clk) begin
    if (bank_b_valid[0] && bank_b_ready[0]) begin
      b <= bank_b[0];
    end
  end

endmodule
